// File: hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath width in bits
`define CPU_DATA_W 32

// general purpose register file
`define CPU_REG_COUNT 16
`define CPU_REG_IDX_W 4

// first instruction fetch address
`define CPU_RESET_VEC 32'h0000_0000

// byte distance between consecutive instruction words
`define CPU_PC_STEP 32'd4

`endif

// File: hw/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	`include "cpu_params.svh"

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_DATA_W-1:0] addr_t;
	typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		T_INH = 4'd0,
		T_CMP = 4'd3,
		T_ALU = 4'd9,
		T_LDI = 4'd10, // long form only, value in next word
		T_LOAD = 4'd11,
		T_STORE = 4'd12,
		T_BRANCH = 4'd13
	} instr_type_t;

	typedef enum logic [2:0] {
		ALU_AND = 3'd0,
		ALU_OR = 3'd1,
		ALU_ADD = 3'd2,
		ALU_SUB = 3'd3,
		ALU_LSL = 3'd4,
		ALU_ASR = 3'd5,
		ALU_LSR = 3'd6,
		ALU_XOR = 3'd7
	} alu_op_t;

	// flags packed as {ltu, lt, eq}
	typedef logic [2:0] ccr_t;
	localparam int CCR_LTU = 2;
	localparam int CCR_LT = 1;
	localparam int CCR_EQ = 0;

endpackage

`default_nettype wire

// File: hw/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

	typedef enum logic [4:0] {
		S_RESET, S_FETCH, S_EVAL, S_ARG,
		S_ALU, S_ALU2, S_MDR2RA,
		S_CMP, S_CMP2,
		S_LOAD, S_LOAD2, S_LOAD3,
		S_STORE, S_STORE2, S_STORE3,
		S_BRANCH,
		S_HALT
	} state_t;

	typedef enum logic {ALU_B, ALU_SVAL} alu_in_t;

	typedef enum logic [1:0] {MAR_MAR, MAR_ALU, MAR_BUS} mar_sel_t;

	typedef enum logic [1:0] {MDR_MDR, MDR_BUS, MDR_ALU, MDR_B} mdr_sel_t;

	typedef enum logic [1:0] {
		PC_PC,
		PC_NEXT,
		PC_REL // next instruction plus sval
	} pc_sel_t;

	typedef enum logic {REG_ALU, REG_MDR} reg_sel_t;

	typedef enum logic {ADDR_PC, ADDR_MAR} addr_sel_t;

endpackage

`default_nettype wire

// File: hw/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_alu import cpu_isa_pkg::*; (
	input wire word_t in_a,
	input wire word_t in_b,
	input wire alu_op_t func,
	output word_t result,
	output ccr_t flags
);

	logic [4:0] shamt;
	logic [`CPU_DATA_W:0] diff;

	assign shamt = in_b[4:0];
	assign diff = {1'b0, in_a} - {1'b0, in_b};

	always_comb begin
		case (func)
			ALU_AND: result = in_a & in_b;
			ALU_OR: result = in_a | in_b;
			ALU_ADD: result = in_a + in_b;
			ALU_SUB: result = diff[`CPU_DATA_W-1:0];
			ALU_LSL: result = in_a << shamt;
			ALU_ASR: result = word_t'($signed(in_a) >>> shamt);
			ALU_LSR: result = in_a >> shamt;
			ALU_XOR: result = in_a ^ in_b;
			default: result = '0;
		endcase
	end

	// flags come from in_a - in_b whatever func is
	always_comb begin
		flags = '0;
		flags[CCR_LTU] = diff[`CPU_DATA_W]; // borrow out
		flags[CCR_LT] = $signed(in_a) < $signed(in_b);
		flags[CCR_EQ] = (in_a == in_b);
	end

endmodule

`default_nettype wire

// File: hw/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_regfile import cpu_isa_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire reg_idx_t read_addr1,
	input wire reg_idx_t read_addr2,
	input wire reg_idx_t write_addr,
	input wire logic write_en,
	input wire word_t write_data,
	output word_t read_data1,
	output word_t read_data2
);

	word_t regs [`CPU_REG_COUNT];

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// combinational reads
	assign read_data1 = regs[read_addr1];
	assign read_data2 = regs[read_addr2];

endmodule

`default_nettype wire

// File: hw/cpu_path_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_path_regs import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic ir_write,
	input wire logic a_write,
	input wire logic b_write,
	input wire logic ccr_write,
	input wire alu_in_t alu2sel,
	input wire mar_sel_t marsel,
	input wire mdr_sel_t mdrsel,
	input wire pc_sel_t pcsel,
	input wire reg_sel_t regsel,
	input wire addr_sel_t addrsel,
	input wire word_t reg_data1,
	input wire word_t reg_data2,
	input wire word_t alu_result,
	input wire ccr_t alu_flags,
	input wire word_t bus_rdata,
	output word_t ir,
	output ccr_t ccr,
	output word_t alu_a,
	output word_t alu_b,
	output word_t reg_wdata,
	output addr_t bus_addr,
	output word_t bus_wdata
);

	word_t a, b, mdr, sval;
	addr_t mar, pc;
	ccr_t ccr_in;

	assign sval = {{(`CPU_DATA_W-15){ir[15]}}, ir[15:1]};

	// lt mirrors ltu in an unsigned cmp
	always_comb begin
		ccr_in = alu_flags;
		if (!ir[24])
			ccr_in[CCR_LT] = alu_flags[CCR_LTU];
	end

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i) begin
			ir <= '0;
			ccr <= '0;
			pc <= `CPU_RESET_VEC;
		end else begin
			if (ir_write)
				ir <= bus_rdata;
			if (ccr_write)
				ccr <= ccr_in;
			case (pcsel)
				PC_NEXT: pc <= pc + `CPU_PC_STEP;
				PC_REL: pc <= pc + sval; // pc already points past the branch
				default: pc <= pc;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (a_write)
			a <= reg_data1;
		if (b_write)
			b <= reg_data2;
		case (marsel)
			MAR_ALU: mar <= alu_result;
			MAR_BUS: mar <= bus_rdata;
			default: mar <= mar;
		endcase
		case (mdrsel)
			MDR_BUS: mdr <= bus_rdata;
			MDR_ALU: mdr <= alu_result;
			MDR_B: mdr <= b;
			default: mdr <= mdr;
		endcase
	end

	assign alu_a = a;
	assign alu_b = (alu2sel == ALU_SVAL) ? sval : b;
	assign reg_wdata = (regsel == REG_MDR) ? mdr : alu_result;
	assign bus_addr = (addrsel == ADDR_MAR) ? mar : pc;
	assign bus_wdata = mdr;

endmodule

`default_nettype wire

// File: hw/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire word_t ir,
	input wire ccr_t ccr,
	input wire logic bus_ack,
	output logic ir_write,
	output logic a_write,
	output logic b_write,
	output logic ccr_write,
	output alu_op_t alu_func,
	output alu_in_t alu2sel,
	output mar_sel_t marsel,
	output mdr_sel_t mdrsel,
	output pc_sel_t pcsel,
	output reg_sel_t regsel,
	output addr_sel_t addrsel,
	output reg_idx_t reg_read_addr1,
	output reg_idx_t reg_read_addr2,
	output reg_idx_t reg_write_addr,
	output logic reg_write,
	output logic bus_cyc,
	output logic bus_write,
	output logic halt
);

	state_t state, state_next;
	instr_type_t ir_type;
	logic [3:0] ir_op;
	reg_idx_t ir_ra, ir_rb, ir_rc;
	logic ir_size;
	logic ltu, lt, eq;

	assign ir_type = instr_type_t'(ir[31:28]);
	assign ir_op = ir[27:24];
	assign ir_ra = ir[23:20];
	assign ir_rb = ir[19:16];
	assign ir_rc = ir[15:12];
	assign ir_size = ir[0];
	assign ltu = ccr[CCR_LTU];
	assign lt = ccr[CCR_LT];
	assign eq = ccr[CCR_EQ];

	assign halt = (state == S_HALT);

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i)
			state <= S_RESET;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		ir_write = 1'b0;
		a_write = 1'b0;
		b_write = 1'b0;
		ccr_write = 1'b0;
		alu_func = ALU_ADD;
		alu2sel = ALU_B;
		marsel = MAR_MAR;
		mdrsel = MDR_MDR;
		pcsel = PC_PC;
		regsel = REG_ALU;
		addrsel = ADDR_PC;
		reg_read_addr1 = ir_ra;
		reg_read_addr2 = ir_rb;
		reg_write_addr = ir_ra;
		reg_write = 1'b0;
		bus_cyc = 1'b0;
		bus_write = 1'b0;

		case (state)
			S_RESET: state_next = S_FETCH;
			S_FETCH: begin
				bus_cyc = 1'b1;
				if (bus_ack) begin
					ir_write = 1'b1;
					pcsel = PC_NEXT;
					state_next = S_EVAL;
				end
			end
			S_EVAL: begin
				a_write = 1'b1; // A <= rA
				b_write = 1'b1; // B <= rB
				if (ir_type == T_LDI)
					state_next = ir_size ? S_ARG : S_HALT;
				else if (ir_size)
					state_next = S_HALT;
				else
					case (ir_type)
						T_INH: state_next = (ir_op == 4'h0) ? S_FETCH : S_HALT; // only op 0 is nop
						T_CMP: state_next = (ir_op[3:1] == 3'h0) ? S_CMP : S_HALT;
						T_ALU: state_next = S_ALU;
						T_LOAD: state_next = (ir_op == 4'h0) ? S_LOAD : S_HALT;
						T_STORE: state_next = (ir_op == 4'h0) ? S_STORE : S_HALT;
						T_BRANCH: state_next = S_BRANCH;
						default: state_next = S_HALT;
					endcase
			end
			S_ARG: begin
				bus_cyc = 1'b1;
				if (bus_ack) begin
					marsel = MAR_BUS;
					mdrsel = MDR_BUS;
					pcsel = PC_NEXT; // skip the argument word
					state_next = S_MDR2RA;
				end
			end
			S_ALU: begin
				reg_read_addr1 = ir_rb;
				reg_read_addr2 = ir_rc;
				a_write = 1'b1; // A <= rB
				b_write = 1'b1; // B <= rC
				state_next = S_ALU2;
			end
			S_ALU2: begin
				alu_func = alu_op_t'(ir_op[2:0]);
				alu2sel = ir_op[3] ? ALU_SVAL : ALU_B; // op bit 3 picks immediate
				mdrsel = MDR_ALU;
				state_next = S_MDR2RA;
			end
			S_MDR2RA: begin
				regsel = REG_MDR;
				reg_write = 1'b1;
				state_next = S_FETCH;
			end
			S_CMP: begin
				alu_func = ALU_SUB;
				state_next = S_CMP2;
			end
			S_CMP2: begin
				alu_func = ALU_SUB;
				ccr_write = 1'b1;
				state_next = S_FETCH;
			end
			S_LOAD: begin
				reg_read_addr1 = ir_rb;
				a_write = 1'b1;
				state_next = S_LOAD2;
			end
			S_LOAD2: begin
				alu2sel = ALU_SVAL;
				marsel = MAR_ALU; // rB + sval
				state_next = S_LOAD3;
			end
			S_LOAD3: begin
				addrsel = ADDR_MAR;
				bus_cyc = 1'b1;
				if (bus_ack) begin
					mdrsel = MDR_BUS;
					state_next = S_MDR2RA;
				end
			end
			S_STORE: begin
				reg_read_addr1 = ir_rb;
				reg_read_addr2 = ir_ra;
				a_write = 1'b1; // A <= rB
				b_write = 1'b1; // B <= rA as store data
				state_next = S_STORE2;
			end
			S_STORE2: begin
				alu2sel = ALU_SVAL;
				marsel = MAR_ALU;
				mdrsel = MDR_B;
				state_next = S_STORE3;
			end
			S_STORE3: begin
				addrsel = ADDR_MAR;
				bus_cyc = 1'b1;
				bus_write = 1'b1;
				if (bus_ack)
					state_next = S_FETCH;
			end
			S_BRANCH: begin
				case (ir_op)
					4'h0: pcsel = PC_REL; // bra
					4'h1: if (eq) pcsel = PC_REL;
					4'h2: if (!eq) pcsel = PC_REL;
					4'h3: if (!(ltu || eq)) pcsel = PC_REL; // bgtu
					4'h4: if (!(lt || eq)) pcsel = PC_REL;
					4'h5: if (!lt) pcsel = PC_REL;
					4'h6: if (lt || eq) pcsel = PC_REL;
					4'h7: if (lt) pcsel = PC_REL;
					4'h8: if (!ltu) pcsel = PC_REL; // bgeu
					4'h9: if (ltu) pcsel = PC_REL;
					4'ha: if (ltu || eq) pcsel = PC_REL;
					default: pcsel = PC_PC; // never
				endcase
				state_next = S_FETCH;
			end
			S_HALT: state_next = S_HALT;
			default: state_next = S_HALT;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	output logic bus_cyc,
	output logic bus_write,
	input wire logic bus_ack,
	output addr_t bus_addr,
	output word_t bus_wdata,
	input wire word_t bus_rdata,
	output logic halt
);

	word_t ir, reg_data1, reg_data2, reg_wdata, alu_a, alu_b, alu_result;
	ccr_t ccr, alu_flags;
	logic ir_write, a_write, b_write, ccr_write, reg_write;
	alu_op_t alu_func;
	alu_in_t alu2sel;
	mar_sel_t marsel;
	mdr_sel_t mdrsel;
	pc_sel_t pcsel;
	reg_sel_t regsel;
	addr_sel_t addrsel;
	reg_idx_t reg_read_addr1, reg_read_addr2, reg_write_addr;

	cpu_control i_control (
		.clk_i, .rst_i, .ir, .ccr, .bus_ack,
		.ir_write, .a_write, .b_write, .ccr_write,
		.alu_func, .alu2sel, .marsel, .mdrsel, .pcsel, .regsel, .addrsel,
		.reg_read_addr1, .reg_read_addr2, .reg_write_addr, .reg_write,
		.bus_cyc, .bus_write, .halt
	);

	cpu_regfile i_regfile (
		.clk_i, .rst_i,
		.read_addr1(reg_read_addr1),
		.read_addr2(reg_read_addr2),
		.write_addr(reg_write_addr),
		.write_en(reg_write),
		.write_data(reg_wdata),
		.read_data1(reg_data1),
		.read_data2(reg_data2)
	);

	cpu_alu i_alu (
		.in_a(alu_a), .in_b(alu_b), .func(alu_func),
		.result(alu_result), .flags(alu_flags)
	);

	cpu_path_regs i_path_regs (
		.clk_i, .rst_i, .ir_write, .a_write, .b_write, .ccr_write,
		.alu2sel, .marsel, .mdrsel, .pcsel, .regsel, .addrsel,
		.reg_data1, .reg_data2, .alu_result, .alu_flags, .bus_rdata,
		.ir, .ccr, .alu_a, .alu_b, .reg_wdata, .bus_addr, .bus_wdata
	);

endmodule

`default_nettype wire

// File: verif/cpu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts import cpu_isa_pkg::*; (
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic bus_cyc,
	input wire logic bus_write,
	input wire logic bus_ack,
	input wire addr_t bus_addr,
	input wire logic halt
);

	write_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_write |-> bus_cyc)
		else $error("bus_write high outside a bus cycle");

	// address and direction frozen until the ack edge
	cycle_held: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_cyc && !bus_ack |=> bus_cyc && $stable(bus_write) && $stable(bus_addr))
		else $error("bus cycle changed before bus_ack");

	quiet_halt: assert property (@(posedge clk_i) disable iff (rst_i)
		halt |-> !bus_cyc)
		else $error("bus_cyc high while halted");

endmodule

bind cpu_top cpu_asserts i_asserts (
	.clk_i, .rst_i, .bus_cyc, .bus_write, .bus_ack, .bus_addr, .halt
);

`default_nettype wire

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb import cpu_isa_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;
	localparam addr_t DATA_BASE = 32'h0000_0800;
	localparam word_t HALT_INSTR = 32'h0100_0000;
	localparam word_t MARKER = 32'h5A5A_C3C3;

	logic clk_i, rst_i, bus_cyc, bus_write, bus_ack, halt;
	addr_t bus_addr;
	word_t bus_wdata, bus_rdata;

	word_t mem [1024]; // program image
	word_t wmem [logic [9:0]]; // words written over the bus
	addr_t store_addr_q[$], exp_addr_q[$];
	word_t store_data_q[$], exp_data_q[$];
	int prog_idx, errors, test_errors, tests_run, tests_failed;

	cpu_top i_dut (
		.clk_i(clk_i), .rst_i(rst_i), .bus_cyc(bus_cyc), .bus_write(bus_write),
		.bus_ack(bus_ack), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata), .halt(halt)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	initial begin : memory_model
		int wait_cnt;
		logic [9:0] idx;
		bus_ack = 1'b0;
		bus_rdata = '0;
		wait_cnt = $urandom(22) % 4; // seeds the generator
		forever begin
			@(negedge clk_i);
			idx = bus_addr[11:2];
			if (rst_i) begin
				bus_ack = 1'b0;
				wmem.delete();
				store_addr_q.delete();
				store_data_q.delete();
			end else if (bus_ack) begin
				bus_ack = 1'b0;
			end else if (bus_cyc) begin
				if (wait_cnt == 0) begin
					if (bus_write) begin
						wmem[idx] = bus_wdata;
						store_addr_q.push_back(bus_addr);
						store_data_q.push_back(bus_wdata);
					end else begin
						bus_rdata = wmem.exists(idx) ? wmem[idx] : mem[idx];
					end
					bus_ack = 1'b1;
					wait_cnt = $urandom % 4;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	function automatic word_t enc_alu(input logic [2:0] op, input reg_idx_t ra,
			input reg_idx_t rb, input reg_idx_t rc);
		return {4'd9, 1'b0, op, ra, rb, rc, 12'h0};
	endfunction

	function automatic word_t enc_alui(input logic [2:0] op, input reg_idx_t ra,
			input reg_idx_t rb, input logic [14:0] imm);
		return {4'd9, 1'b1, op, ra, rb, imm, 1'b0};
	endfunction

	// load is type 11 and store type 12
	function automatic word_t enc_mem(input logic [3:0] typ, input reg_idx_t ra,
			input reg_idx_t rb, input int off);
		logic [14:0] o;
		o = off[14:0];
		return {typ, 4'h0, ra, rb, o, 1'b0};
	endfunction

	function automatic word_t enc_cmp(input logic sgn, input reg_idx_t ra, input reg_idx_t rb);
		return {4'd3, 3'b000, sgn, ra, rb, 16'h0};
	endfunction

	function automatic word_t enc_br(input logic [3:0] cond, input int off);
		logic [14:0] o;
		o = off[14:0];
		return {4'd13, cond, 8'h0, o, 1'b0};
	endfunction

	function automatic word_t sext15(input logic [14:0] v);
		return {{17{v[14]}}, v};
	endfunction

	function automatic word_t alu_model(input logic [2:0] op, input word_t a, input word_t b);
		case (op)
			3'd0: return a & b;
			3'd1: return a | b;
			3'd2: return a + b;
			3'd3: return a - b;
			3'd4: return a << b[4:0];
			3'd5: return a[31] ? ~(~a >> b[4:0]) : a >> b[4:0];
			3'd6: return a >> b[4:0];
			default: return a ^ b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [3:0] cond, input logic ltu,
			input logic lt, input logic eq);
		case (cond)
			4'd0: return 1'b1;
			4'd1: return eq;
			4'd2: return !eq;
			4'd3: return !ltu && !eq; // above
			4'd4: return !lt && !eq;
			4'd5: return !lt;
			4'd6: return lt || eq;
			4'd7: return lt;
			4'd8: return !ltu;
			4'd9: return ltu;
			4'd10: return ltu || eq;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	// holds reset while the next program is written
	task automatic begin_program();
		@(negedge clk_i);
		rst_i = 1'b1;
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'hF000_0000 | i; // undefined type so a runaway fetch halts
		exp_addr_q.delete();
		exp_data_q.delete();
		prog_idx = 0;
		test_errors = 0;
	endtask

	task automatic release_reset();
		repeat (3) @(negedge clk_i);
		rst_i = 1'b0;
	endtask

	task automatic emit(input word_t w);
		mem[prog_idx] = w;
		prog_idx++;
	endtask

	task automatic emit_ldi(input reg_idx_t ra, input word_t val);
		emit({4'd10, 4'h0, ra, 19'h0, 1'b1});
		emit(val);
	endtask

	task automatic expect_store(input int off, input word_t data);
		exp_addr_q.push_back(DATA_BASE + off);
		exp_data_q.push_back(data);
	endtask

	// r15 holds DATA_BASE in every program
	task automatic emit_store(input reg_idx_t ra, input int off, input word_t data);
		emit(enc_mem(4'd12, ra, 4'd15, off));
		expect_store(off, data);
	endtask

	task automatic run_to_halt(input string test_name);
		int cycles;
		cycles = 0;
		while (halt !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk_i);
			cycles++;
		end
		if (halt !== 1'b1) begin
			$display("%s timed out waiting for halt", test_name);
			test_errors++;
		end
	endtask

	task automatic compare_stores();
		if (store_addr_q.size() != exp_addr_q.size()) begin
			$display("saw %0d bus writes where %0d were expected",
				store_addr_q.size(), exp_addr_q.size());
			test_errors++;
		end else begin
			for (int i = 0; i < exp_addr_q.size(); i++) begin
				check_addr($sformatf("bus_addr of store %0d", i), store_addr_q[i], exp_addr_q[i]);
				check_word($sformatf("bus_wdata of store %0d", i), store_data_q[i], exp_data_q[i]);
			end
		end
	endtask

	task automatic finish_test(input string test_name);
		$display("%s finished with %0d errors", test_name, test_errors);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		errors += test_errors;
	endtask

	task automatic test_reset_fetch();
		int cycles;
		begin_program();
		emit(HALT_INSTR);
		release_reset();
		cycles = 0;
		while (bus_cyc !== 1'b1 && cycles < 20) begin
			@(negedge clk_i);
			cycles++;
		end
		if (bus_cyc !== 1'b1) begin
			$display("no bus cycle started after reset");
			test_errors++;
		end else begin
			check_addr("bus_addr", bus_addr, `CPU_RESET_VEC);
			check_bit("bus_write", bus_write, 1'b0);
		end
		run_to_halt("reset_fetch");
		finish_test("reset_fetch");
	endtask

	task automatic test_alu_ops();
		word_t x, y;
		logic [14:0] imm;
		x = 32'h8765_4321;
		y = 32'h0F0F_1235;
		imm = 15'h4A53; // negative with shift amount 19
		begin_program();
		emit_ldi(4'd15, DATA_BASE);
		emit_ldi(4'd1, x);
		emit_ldi(4'd2, y);
		for (int op = 0; op < 8; op++) begin
			emit(enc_alu(3'(op), 4'd3, 4'd1, 4'd2));
			emit_store(4'd3, op * 4, alu_model(3'(op), x, y));
			emit(enc_alui(3'(op), 4'd4, 4'd1, imm));
			emit_store(4'd4, 32 + op * 4, alu_model(3'(op), x, sext15(imm)));
		end
		emit(HALT_INSTR);
		release_reset();
		run_to_halt("alu_ops");
		compare_stores();
		finish_test("alu_ops");
	endtask

	task automatic test_load_store();
		begin_program();
		emit_ldi(4'd15, DATA_BASE);
		emit_ldi(4'd4, 32'h1234_ABCD);
		emit_ldi(4'd5, 32'h0DEF_0042);
		emit_store(4'd4, 8, 32'h1234_ABCD);
		emit_store(4'd5, -12, 32'h0DEF_0042);
		emit(enc_mem(4'd11, 4'd6, 4'd15, 8));
		emit(enc_mem(4'd11, 4'd7, 4'd15, -12));
		emit_store(4'd6, 32, 32'h1234_ABCD);
		emit_store(4'd7, -32, 32'h0DEF_0042);
		emit(HALT_INSTR);
		release_reset();
		run_to_halt("load_store");
		compare_stores();
		finish_test("load_store");
	endtask

	task automatic test_branches();
		word_t pa [3];
		word_t pb [3];
		int slot;
		logic exp_ltu, exp_lt, exp_eq;
		pa = '{32'h0000_0005, 32'hFFFF_FFF0, 32'h0000_0003};
		pb = '{32'h0000_0005, 32'h0000_0003, 32'hFFFF_FFF0};
		begin_program();
		emit_ldi(4'd15, DATA_BASE);
		emit_ldi(4'd9, MARKER);
		slot = 0;
		for (int p = 0; p < 3; p++) begin
			emit_ldi(4'd10, pa[p]);
			emit_ldi(4'd11, pb[p]);
			for (int s = 0; s < 2; s++) begin
				emit(enc_cmp(s[0], 4'd10, 4'd11));
				exp_eq = (pa[p] == pb[p]);
				exp_ltu = (pa[p] < pb[p]);
				exp_lt = (s == 1) ? ($signed(pa[p]) < $signed(pb[p])) : exp_ltu;
				for (int c = 0; c < 12; c++) begin
					emit(enc_br(4'(c), 4)); // taken skips the marker store
					emit(enc_mem(4'd12, 4'd9, 4'd15, slot * 4));
					if (!branch_taken(4'(c), exp_ltu, exp_lt, exp_eq))
						expect_store(slot * 4, MARKER);
					slot++;
				end
			end
		end
		emit(HALT_INSTR);
		release_reset();
		run_to_halt("branches");
		compare_stores();
		finish_test("branches");
	endtask

	task automatic test_halt();
		begin_program();
		emit(32'h0000_0000); // nop
		emit(HALT_INSTR);
		emit(enc_mem(4'd12, 4'd0, 4'd0, 0));
		release_reset();
		run_to_halt("halt");
		repeat (16) begin
			@(negedge clk_i);
			check_bit("halt", halt, 1'b1);
			check_bit("bus_cyc", bus_cyc, 1'b0);
		end
		compare_stores();
		finish_test("halt");
	endtask

	task automatic test_undefined();
		word_t bad [2];
		bad = '{32'h4000_0000, enc_alu(3'd2, 4'd1, 4'd2, 4'd3) | 32'h1};
		for (int i = 0; i < 2; i++) begin
			begin_program();
			emit(bad[i]);
			emit(enc_mem(4'd12, 4'd0, 4'd0, 0));
			release_reset();
			run_to_halt("undefined");
			compare_stores();
			finish_test($sformatf("undefined %h", bad[i]));
		end
	endtask

	initial begin
		rst_i = 1'b1;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		prog_idx = 0;
		test_reset_fetch();
		test_alu_ops();
		test_load_store();
		test_branches();
		test_halt();
		test_undefined();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/cpu_path_regs.sv
hw/cpu_control.sv
hw/cpu_top.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module cpu_tb -o cpu_tb_sim
	./obj_dir/cpu_tb_sim > sim.log 2>&1; cat sim.log
	! grep -q "TESTS FAILED" sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
